//--- sim.f
verilog/readout_pkg.sv
verilog/readout_regs.sv
verilog/dds_mixer.sv
verilog/sample_fifo.sv
verilog/decim_output.sv
verilog/readout_top.sv
verif/readout_props.sv
verif/tb_readout.sv

//--- run_sim.sh
#!/bin/sh
# Build the readout testbench with Verilator, run it, and check the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
	--top-module tb_readout -o sim_readout > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/sim_readout > sim.log 2>&1
cat sim.log
grep -qx "TEST PASSED" sim.log && exit 0 || exit 1

//--- verif/tb_readout.sv
//####################################################################
// Readout testbench: table-driven streams through the downconverter
// with a reference mixer model and per-output scoreboards.
//####################################################################
`timescale 1ns/1ps

module tb_readout import readout_pkg::*; ();

	localparam int N_LANES    = 8;
	localparam int FIFO_DEPTH = 8;
	localparam int NUM_TESTS  = 6;

	typedef struct packed {
		logic [15:0] freq;
		logic [1:0]  outsel;
		logic [15:0] nwords;
		logic        rand_pat;
		logic [7:0]  bp_pct;
	} test_row_t;

	// Frequency, output select, words, random pattern, back-pressure in percent.
	localparam test_row_t TESTS [NUM_TESTS] = '{
		'{freq: 16'h0000, outsel: 2'd3, nwords: 16'd16, rand_pat: 1'b0, bp_pct: 8'd0},
		'{freq: 16'h1000, outsel: 2'd3, nwords: 16'd24, rand_pat: 1'b1, bp_pct: 8'd0},
		'{freq: 16'h0b40, outsel: 2'd3, nwords: 16'd40, rand_pat: 1'b1, bp_pct: 8'd40},
		'{freq: 16'h2000, outsel: 2'd1, nwords: 16'd20, rand_pat: 1'b1, bp_pct: 8'd30},
		'{freq: 16'h3000, outsel: 2'd2, nwords: 16'd20, rand_pat: 1'b1, bp_pct: 8'd30},
		'{freq: 16'h0b40, outsel: 2'd3, nwords: 16'd12, rand_pat: 1'b0, bp_pct: 8'd70}
	};

	logic                    aclk;
	logic                    rst_n;
	logic                    reg_we;
	logic [1:0]              reg_addr;
	logic [31:0]             reg_wdata;
	logic [N_LANES*16-1:0]   s_axis_tdata;
	logic                    s_axis_tvalid;
	logic                    s_axis_tready;
	logic [N_LANES*32-1:0]   m0_axis_tdata;
	logic                    m0_axis_tvalid;
	logic                    m0_axis_tready;
	logic [31:0]             m1_axis_tdata;
	logic                    m1_axis_tvalid;
	logic                    m1_axis_tready;

	logic [N_LANES*32-1:0]   exp_m0 [$];
	logic [31:0]             exp_m1 [$];
	logic [1:0]              cur_outsel;
	int                      bp_pct;
	int                      m0_beats;
	int                      m1_beats;
	int                      checks;
	int                      errors;

	readout_top #(
		.N_LANES    (N_LANES),
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_dut (
		.aclk           (aclk),
		.rst_n          (rst_n),
		.reg_we         (reg_we),
		.reg_addr       (reg_addr),
		.reg_wdata      (reg_wdata),
		.s_axis_tdata   (s_axis_tdata),
		.s_axis_tvalid  (s_axis_tvalid),
		.s_axis_tready  (s_axis_tready),
		.m0_axis_tdata  (m0_axis_tdata),
		.m0_axis_tvalid (m0_axis_tvalid),
		.m0_axis_tready (m0_axis_tready),
		.m1_axis_tdata  (m1_axis_tdata),
		.m1_axis_tvalid (m1_axis_tvalid),
		.m1_axis_tready (m1_axis_tready)
	);

	bind readout_top readout_props #(
		.N_LANES    (N_LANES),
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_props (
		.aclk           (aclk),
		.rst_n          (rst_n),
		.m0_axis_tdata  (m0_axis_tdata),
		.m0_axis_tvalid (m0_axis_tvalid),
		.m0_axis_tready (m0_axis_tready),
		.m1_axis_tdata  (m1_axis_tdata),
		.m1_axis_tvalid (m1_axis_tvalid),
		.m1_axis_tready (m1_axis_tready),
		.fifo_count     (fifo_count),
		.pop            (pop),
		.mix_valid      (mix_valid)
	);

	// Reference mixer with lane k at phase base + k*freq in Q15.
	function automatic logic [N_LANES*32-1:0] mix_expected(logic [N_LANES*16-1:0] x_word,
			logic [15:0] base, logic [15:0] freq);
		logic [N_LANES*32-1:0] res;
		logic [15:0]           ph;
		logic [LUT_BITS-1:0]   ci;
		logic [LUT_BITS-1:0]   si;
		sample_t               xs;
		int                    pi;
		int                    pq;
		for (int k = 0; k < N_LANES; k++) begin
			ph = base + 16'(k) * freq;
			ci = ph[15 -: LUT_BITS];
			si = ci - LUT_BITS'(4);
			xs = x_word[16*k +: 16];
			pi = (int'(xs) * int'(COS_LUT[ci])) >>> 15;
			pq = (-(int'(xs) * int'(COS_LUT[si]))) >>> 15;
			res[32*k +: 16]      = pi[15:0];
			res[32*k + 16 +: 16] = pq[15:0];
		end
		return res;
	endfunction

	// Each lane sum shifted right by log2 of the lane count.
	function automatic logic [31:0] avg_expected(logic [N_LANES*32-1:0] w);
		int      sum_i;
		int      sum_q;
		sample_t v;
		sum_i = 0;
		sum_q = 0;
		for (int k = 0; k < N_LANES; k++) begin
			v = w[32*k +: 16];
			sum_i += int'(v);
			v = w[32*k + 16 +: 16];
			sum_q += int'(v);
		end
		sum_i = sum_i >>> $clog2(N_LANES);
		sum_q = sum_q >>> $clog2(N_LANES);
		return {sum_q[15:0], sum_i[15:0]};
	endfunction

	function automatic logic [N_LANES*16-1:0] make_word(int w, logic rand_pat);
		logic [N_LANES*16-1:0] res;
		for (int k = 0; k < N_LANES; k++) begin
			if (rand_pat)
				res[16*k +: 16] = 16'($urandom());
			else
				res[16*k +: 16] = 16'((w * N_LANES + k) * 1237 - 30000);
		end
		return res;
	endfunction

	task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
		reg_we    = 1'b1;
		reg_addr  = addr;
		reg_wdata = data;
		@(posedge aclk);
		#1;
		reg_we = 1'b0;
	endtask

	task automatic wait_drain();
		while (exp_m0.size() != 0 || exp_m1.size() != 0) begin
			@(posedge aclk);
			#1;
		end
		repeat (3) @(posedge aclk);
		#1;
	endtask

	initial begin
		aclk = 1'b0;
		forever #4 aclk = ~aclk;
	end

	// Output ready is redrawn every cycle.
	initial begin
		m0_axis_tready = 1'b0;
		m1_axis_tready = 1'b0;
		forever begin
			@(posedge aclk);
			#1;
			m0_axis_tready = ($urandom_range(99) >= bp_pct);
			m1_axis_tready = ($urandom_range(99) >= bp_pct);
		end
	end

	// Scoreboards sample mid-cycle where the handshake is stable.
	always @(negedge aclk) begin
		logic [N_LANES*32-1:0] want_m0;
		logic [31:0]           want_m1;
		int                    pending;
		if (rst_n) begin
			if (m0_axis_tvalid && m0_axis_tready) begin
				m0_beats++;
				checks++;
				assert (exp_m0.size() != 0) else begin
					$display("ERROR: beat on m0 with no word outstanding");
					errors++;
				end
				if (exp_m0.size() != 0) begin
					want_m0 = exp_m0.pop_front();
					assert (m0_axis_tdata == want_m0) else begin
						$display("FAIL m0_axis_tdata expected %h actual %h", want_m0, m0_axis_tdata);
						errors++;
					end
				end
			end
			if (m1_axis_tvalid && m1_axis_tready) begin
				m1_beats++;
				checks++;
				assert (exp_m1.size() != 0) else begin
					$display("ERROR: beat on m1 with no word outstanding");
					errors++;
				end
				if (exp_m1.size() != 0) begin
					want_m1 = exp_m1.pop_front();
					assert (m1_axis_tdata == want_m1) else begin
						$display("FAIL m1_axis_tdata expected %h actual %h", want_m1, m1_axis_tdata);
						errors++;
					end
				end
			end
			// Input may stall only once the FIFO is close to full.
			if (s_axis_tvalid && !s_axis_tready) begin
				checks++;
				pending = (exp_m0.size() > exp_m1.size()) ? exp_m0.size() : exp_m1.size();
				assert (pending >= FIFO_DEPTH - 2) else begin
					$display("FAIL s_axis_tready expected %h actual %h with %0d words pending",
						1'b1, s_axis_tready, pending);
					errors++;
				end
			end
			// A disabled stream stays idle.
			assert (cur_outsel[0] || !m0_axis_tvalid) else begin
				$display("ERROR: m0 valid went high while m0 is disabled");
				errors++;
			end
			assert (cur_outsel[1] || !m1_axis_tvalid) else begin
				$display("ERROR: m1 valid went high while m1 is disabled");
				errors++;
			end
		end
	end

	// Watchdog allows 40 cycles per word over all rows plus margin.
	initial begin
		int cycles;
		cycles = 1000;
		for (int t = 0; t < NUM_TESTS; t++)
			cycles += 40 * int'(TESTS[t].nwords);
		repeat (cycles) @(posedge aclk);
		$display("ERROR: watchdog expired after %0d cycles, the streams did not complete",
			cycles);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		test_row_t             row;
		logic [N_LANES*16-1:0] word;
		logic [N_LANES*32-1:0] m0_word;
		logic [15:0]           model_phase;
		logic                  taken;
		int                    base_err;
		rst_n         = 1'b0;
		reg_we        = 1'b0;
		reg_addr      = '0;
		reg_wdata     = '0;
		s_axis_tdata  = '0;
		s_axis_tvalid = 1'b0;
		cur_outsel    = 2'd0;
		bp_pct        = 0;
		m0_beats      = 0;
		m1_beats      = 0;
		checks        = 0;
		errors        = 0;
		void'($urandom(32'h9a08d9e8));

		repeat (4) @(posedge aclk);
		@(negedge aclk);
		checks++;
		assert (!s_axis_tready && !m0_axis_tvalid && !m1_axis_tvalid) else begin
			$display("ERROR: ready or valid outputs not low during reset");
			errors++;
		end
		@(posedge aclk);
		#1;
		rst_n = 1'b1;
		repeat (2) @(posedge aclk);
		#1;

		for (int t = 0; t < NUM_TESTS; t++) begin
			row      = TESTS[t];
			base_err = errors;
			m0_beats = 0;
			m1_beats = 0;
			write_reg(REG_OUTSEL, {30'd0, row.outsel});
			cur_outsel = row.outsel;
			// Every frequency write restarts the NCO at phase zero.
			write_reg(REG_FREQ, {16'd0, row.freq});
			bp_pct      = int'(row.bp_pct);
			model_phase = '0;
			for (int w = 0; w < int'(row.nwords); w++) begin
				word          = make_word(w, row.rand_pat);
				s_axis_tdata  = word;
				s_axis_tvalid = 1'b1;
				do begin
					@(negedge aclk);
					taken = s_axis_tready;
					@(posedge aclk);
					#1;
				end while (!taken);
				m0_word = mix_expected(word, model_phase, row.freq);
				if (row.outsel[0])
					exp_m0.push_back(m0_word);
				if (row.outsel[1])
					exp_m1.push_back(avg_expected(m0_word));
				model_phase = model_phase + 16'(N_LANES) * row.freq;
			end
			s_axis_tvalid = 1'b0;
			wait_drain();

			checks++;
			assert (m0_beats == (row.outsel[0] ? int'(row.nwords) : 0)) else begin
				$display("FAIL m0_axis_tvalid beats expected %h actual %h",
					row.outsel[0] ? int'(row.nwords) : 0, m0_beats);
				errors++;
			end
			checks++;
			assert (m1_beats == (row.outsel[1] ? int'(row.nwords) : 0)) else begin
				$display("FAIL m1_axis_tvalid beats expected %h actual %h",
					row.outsel[1] ? int'(row.nwords) : 0, m1_beats);
				errors++;
			end
			$display("test %0d: freq %h outsel %0d words %0d m0 %0d m1 %0d errors %0d",
				t, row.freq, row.outsel, row.nwords, m0_beats, m1_beats, errors - base_err);
		end

		$display("summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- verif/readout_props.sv
//####################################################################
// Readout properties: stream hold under back-pressure and FIFO
// occupancy and overflow safety, bound to the readout top level.
//####################################################################
`timescale 1ns/1ps

module readout_props #(
	parameter int N_LANES    = 8,
	parameter int FIFO_DEPTH = 8
) (
	input logic                            aclk,
	input logic                            rst_n,
	input logic [N_LANES*32-1:0]           m0_axis_tdata,
	input logic                            m0_axis_tvalid,
	input logic                            m0_axis_tready,
	input logic [31:0]                     m1_axis_tdata,
	input logic                            m1_axis_tvalid,
	input logic                            m1_axis_tready,
	input logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count,
	input logic                            pop,
	input logic                            mix_valid
);

	// A beat that is not taken holds its valid and data.
	m0_hold: assert property (@(posedge aclk) disable iff (!rst_n)
		m0_axis_tvalid && !m0_axis_tready |=> m0_axis_tvalid && $stable(m0_axis_tdata))
		else $error("m0 valid or data changed while ready was low");

	m1_hold: assert property (@(posedge aclk) disable iff (!rst_n)
		m1_axis_tvalid && !m1_axis_tready |=> m1_axis_tvalid && $stable(m1_axis_tdata))
		else $error("m1 valid or data changed while ready was low");

	fifo_bound: assert property (@(posedge aclk) disable iff (!rst_n)
		fifo_count <= ($clog2(FIFO_DEPTH+1))'(FIFO_DEPTH))
		else $error("FIFO count went above its depth");

	// A full FIFO only takes a mixer word in a cycle that also pops.
	full_write: assert property (@(posedge aclk) disable iff (!rst_n)
		mix_valid && (fifo_count == ($clog2(FIFO_DEPTH+1))'(FIFO_DEPTH)) |-> pop)
		else $error("mixer word written into a full FIFO");

endmodule

//--- verilog/readout_top.sv
//####################################################################
// Readout top: register block, DDS mixer, sample FIFO and the
// decimating output stage of one downconverter channel.
//####################################################################
`timescale 1ns/1ps

module readout_top import readout_pkg::*; #(
	parameter int N_LANES    = 8,
	parameter int FIFO_DEPTH = 8
) (
	input  logic                  aclk,
	input  logic                  rst_n,
	// Register writes.
	input  logic                  reg_we,
	input  logic [1:0]            reg_addr,
	input  logic [31:0]           reg_wdata,
	// Input samples.
	input  sample_t [N_LANES-1:0] s_axis_tdata,
	input  logic                  s_axis_tvalid,
	output logic                  s_axis_tready,
	// Full-rate mixed stream.
	output iq_t [N_LANES-1:0]     m0_axis_tdata,
	output logic                  m0_axis_tvalid,
	input  logic                  m0_axis_tready,
	// Decimated stream.
	output iq_t                   m1_axis_tdata,
	output logic                  m1_axis_tvalid,
	input  logic                  m1_axis_tready
);

	readout_cfg_t                    cfg;
	iq_t [N_LANES-1:0]               mix_word;
	logic                            mix_valid;
	iq_t [N_LANES-1:0]               head;
	logic                            not_empty;
	logic                            pop;
	logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count;

	readout_regs i_regs (
		.aclk      (aclk),
		.rst_n     (rst_n),
		.reg_we    (reg_we),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.cfg       (cfg)
	);

	dds_mixer #(
		.N_LANES    (N_LANES),
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_mixer (
		.aclk          (aclk),
		.rst_n         (rst_n),
		.cfg           (cfg),
		.s_axis_tdata  (s_axis_tdata),
		.s_axis_tvalid (s_axis_tvalid),
		.s_axis_tready (s_axis_tready),
		.fifo_count    (fifo_count),
		.mix_word      (mix_word),
		.mix_valid     (mix_valid)
	);

	sample_fifo #(
		.DEPTH (FIFO_DEPTH),
		.WIDTH ($bits(iq_t) * N_LANES)
	) i_fifo (
		.aclk      (aclk),
		.rst_n     (rst_n),
		.wr        (mix_valid),
		.wdata     (mix_word),
		.pop       (pop),
		.head      (head),
		.not_empty (not_empty),
		.count     (fifo_count)
	);

	decim_output #(
		.N_LANES (N_LANES)
	) i_output (
		.aclk           (aclk),
		.rst_n          (rst_n),
		.cfg            (cfg),
		.head           (head),
		.not_empty      (not_empty),
		.pop            (pop),
		.m0_axis_tdata  (m0_axis_tdata),
		.m0_axis_tvalid (m0_axis_tvalid),
		.m0_axis_tready (m0_axis_tready),
		.m1_axis_tdata  (m1_axis_tdata),
		.m1_axis_tvalid (m1_axis_tvalid),
		.m1_axis_tready (m1_axis_tready)
	);

endmodule

//--- verilog/decim_output.sv
//####################################################################
// Output stage: lane average of the FIFO head and the registered
// m0 (full rate) and m1 (decimated) streams with back-pressure.
//####################################################################
`timescale 1ns/1ps

module decim_output import readout_pkg::*; #(
	parameter int N_LANES = 8
) (
	input  logic              aclk,
	input  logic              rst_n,
	input  readout_cfg_t      cfg,
	input  iq_t [N_LANES-1:0] head,
	input  logic              not_empty,
	output logic              pop,
	output iq_t [N_LANES-1:0] m0_axis_tdata,
	output logic              m0_axis_tvalid,
	input  logic              m0_axis_tready,
	output iq_t               m1_axis_tdata,
	output logic              m1_axis_tvalid,
	input  logic              m1_axis_tready
);

	localparam int SHIFT = $clog2(N_LANES);
	localparam int SUM_W = 16 + SHIFT;

	logic signed [SUM_W-1:0] sum_i;
	logic signed [SUM_W-1:0] sum_q;
	iq_t                     avg;
	logic                    m0_busy;
	logic                    m1_busy;

	// Lane sums, wide enough not to overflow.
	always_comb begin
		sum_i = '0;
		sum_q = '0;
		for (int k = 0; k < N_LANES; k++) begin
			sum_i = sum_i + SUM_W'(head[k].i);
			sum_q = sum_q + SUM_W'(head[k].q);
		end
	end

	// Divide by the lane count.
	assign avg.i = sum_i[SHIFT +: 16];
	assign avg.q = sum_q[SHIFT +: 16];

	// A beat still waiting blocks the reload.
	assign m0_busy = m0_axis_tvalid && !m0_axis_tready;
	assign m1_busy = m1_axis_tvalid && !m1_axis_tready;
	assign pop     = not_empty && !m0_busy && !m1_busy;

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			m0_axis_tvalid <= 1'b0;
			m1_axis_tvalid <= 1'b0;
		end else if (pop) begin
			// Disabled outputs stay idle.
			m0_axis_tvalid <= cfg.m0_en;
			m1_axis_tvalid <= cfg.m1_en;
		end else begin
			if (m0_axis_tready)
				m0_axis_tvalid <= 1'b0;
			if (m1_axis_tready)
				m1_axis_tvalid <= 1'b0;
		end
	end

	always_ff @(posedge aclk) begin
		if (pop) begin
			m0_axis_tdata <= head;
			m1_axis_tdata <= avg;
		end
	end

endmodule

//--- verilog/sample_fifo.sv
//####################################################################
// Synchronous FIFO of mixed words with an occupancy count,
// write and pop allowed in the same cycle.
//####################################################################
`timescale 1ns/1ps

module sample_fifo #(
	parameter int DEPTH = 8,
	parameter int WIDTH = 32
) (
	input  logic                       aclk,
	input  logic                       rst_n,
	input  logic                       wr,
	input  logic [WIDTH-1:0]           wdata,
	input  logic                       pop,
	output logic [WIDTH-1:0]           head,
	output logic                       not_empty,
	output logic [$clog2(DEPTH+1)-1:0] count
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	// Wrap at DEPTH, not a power of two necessarily.
	function automatic logic [PTR_W-1:0] ptr_next(logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_ff @(posedge aclk) begin
		if (wr)
			mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			case ({wr, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// First-word fall-through read.
	assign head      = mem[rd_ptr];
	assign not_empty = (count != '0);

endmodule

//--- verilog/dds_mixer.sv
//####################################################################
// DDS mixer: per-lane NCO phases, table lookup in stage one and the
// registered complex products in stage two.
//####################################################################
`timescale 1ns/1ps

module dds_mixer import readout_pkg::*; #(
	parameter int N_LANES    = 8,
	parameter int FIFO_DEPTH = 8
) (
	input  logic                            aclk,
	input  logic                            rst_n,
	input  readout_cfg_t                    cfg,
	input  sample_t [N_LANES-1:0]           s_axis_tdata,
	input  logic                            s_axis_tvalid,
	output logic                            s_axis_tready,
	input  logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count,
	output iq_t [N_LANES-1:0]               mix_word,
	output logic                            mix_valid
);

	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	logic               in_en;
	logic               accept;
	phase_t             phase_acc;
	phase_t             phase_base;
	phase_t             lane_phase [N_LANES];
	logic               s1_valid;
	sample_t            s1_x   [N_LANES];
	sample_t            s1_cos [N_LANES];
	sample_t            s1_sin [N_LANES];
	logic signed [31:0] prod_i [N_LANES];
	logic signed [31:0] prod_q [N_LANES];

	// Input opens one cycle out of reset.
	always_ff @(posedge aclk) begin
		if (!rst_n)
			in_en <= 1'b0;
		else
			in_en <= 1'b1;
	end

	// Leave room for the two words that may be in the pipe.
	assign s_axis_tready = in_en && (fifo_count <= CNT_W'(FIFO_DEPTH - 3));
	assign accept        = s_axis_tvalid && s_axis_tready;

	// Frequency load restarts the phase at zero.
	assign phase_base = cfg.freq_load ? '0 : phase_acc;

	always_comb begin
		for (int k = 0; k < N_LANES; k++)
			lane_phase[k] = phase_base + phase_t'(k) * cfg.freq;
	end

	always_ff @(posedge aclk) begin
		if (!rst_n)
			phase_acc <= '0;
		else if (accept)
			phase_acc <= phase_base + phase_t'(N_LANES) * cfg.freq;
		else if (cfg.freq_load)
			phase_acc <= '0;
	end

	// Stage one: samples and table values.
	always_ff @(posedge aclk) begin
		if (!rst_n)
			s1_valid <= 1'b0;
		else
			s1_valid <= accept;
	end

	always_ff @(posedge aclk) begin
		if (accept) begin
			for (int k = 0; k < N_LANES; k++) begin
				s1_x[k]   <= s_axis_tdata[k];
				s1_cos[k] <= lut_cos(lane_phase[k]);
				s1_sin[k] <= lut_sin(lane_phase[k]);
			end
		end
	end

	// x*cos and -x*sin in Q15.
	always_comb begin
		for (int k = 0; k < N_LANES; k++) begin
			prod_i[k] = s1_x[k] * s1_cos[k];
			prod_q[k] = -(s1_x[k] * s1_sin[k]);
		end
	end

	// Stage two.
	always_ff @(posedge aclk) begin
		if (!rst_n)
			mix_valid <= 1'b0;
		else
			mix_valid <= s1_valid;
	end

	always_ff @(posedge aclk) begin
		if (s1_valid) begin
			for (int k = 0; k < N_LANES; k++) begin
				mix_word[k].i <= prod_i[k][30:15];
				mix_word[k].q <= prod_q[k][30:15];
			end
		end
	end

endmodule

//--- verilog/readout_regs.sv
//####################################################################
// Readout configuration registers: output enables, NCO frequency
// and a one-cycle pulse on every frequency write.
//####################################################################
`timescale 1ns/1ps

module readout_regs import readout_pkg::*; (
	input  logic         aclk,
	input  logic         rst_n,
	input  logic         reg_we,
	input  logic [1:0]   reg_addr,
	input  logic [31:0]  reg_wdata,
	output readout_cfg_t cfg
);

	logic outsel_wr;
	logic freq_wr;

	assign outsel_wr = reg_we && (reg_addr == REG_OUTSEL);
	assign freq_wr   = reg_we && (reg_addr == REG_FREQ);

	// Output enables.
	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			cfg.m0_en <= 1'b0;
			cfg.m1_en <= 1'b0;
		end else if (outsel_wr) begin
			cfg.m0_en <= reg_wdata[0];
			cfg.m1_en <= reg_wdata[1];
		end
	end

	// Frequency word, load strobe lasts one cycle.
	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			cfg.freq      <= '0;
			cfg.freq_load <= 1'b0;
		end else begin
			cfg.freq_load <= freq_wr;
			if (freq_wr)
				cfg.freq <= reg_wdata[15:0];
		end
	end

endmodule

//--- verilog/readout_pkg.sv
//####################################################################
// Readout package: sample, phase and IQ types, the NCO cosine table
// and the configuration struct shared by the downconverter blocks.
//####################################################################
package readout_pkg;

	typedef logic signed [15:0] sample_t;
	typedef logic [15:0] phase_t;

	// Imaginary in the upper half, real in the lower half.
	typedef struct packed {
		sample_t q;
		sample_t i;
	} iq_t;

	// Register map.
	localparam logic [1:0] REG_OUTSEL = 2'd0;
	localparam logic [1:0] REG_FREQ   = 2'd1;

	// Phase bits that index the table.
	localparam int LUT_BITS = 4;

	// round(32767 * cos(2*pi*n/16)).
	localparam sample_t COS_LUT [2**LUT_BITS] = '{
		32767,  30273,  23170,  12539,
		0,     -12539, -23170, -30273,
		-32767, -30273, -23170, -12539,
		0,      12539,  23170,  30273
	};

	function automatic sample_t lut_cos(phase_t ph);
		return COS_LUT[ph[$bits(phase_t)-1 -: LUT_BITS]];
	endfunction

	// Sine is the cosine a quarter turn back.
	function automatic sample_t lut_sin(phase_t ph);
		logic [LUT_BITS-1:0] idx;
		idx = ph[$bits(phase_t)-1 -: LUT_BITS] - LUT_BITS'(4);
		return COS_LUT[idx];
	endfunction

	typedef struct packed {
		logic   m0_en;
		logic   m1_en;
		phase_t freq;
		logic   freq_load;
	} readout_cfg_t;

endpackage
